// File: hdl/exu_pkg.sv
// Shared widths, opcodes and payload structs for the execution stage slice.
// The RTL units name these types in their port lists and import the
// package in their bodies when they need the constants.

`default_nettype none

package exu_pkg;

  localparam int XLEN       = 32;
  localparam int RFIDX_W    = 5;
  localparam int RF_NUM     = 1 << RFIDX_W;
  localparam int OITF_DEPTH = 2;
  localparam int ITAG_W     = 1;    // Wide enough to index the OITF

  // Decoded operation classes
  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_XOR  = 3'd2,
    OP_OR   = 3'd3,
    OP_ADDI = 3'd4,
    OP_LOAD = 3'd5
  } alu_op_e;

  typedef struct packed {
    alu_op_e            op;
    logic [RFIDX_W-1:0] rs1idx;
    logic [RFIDX_W-1:0] rs2idx;
    logic [RFIDX_W-1:0] rdidx;
    logic               rdwen;
    logic [XLEN-1:0]    imm;
  } disp_instr_t;

  typedef struct packed {
    alu_op_e            op;
    logic [XLEN-1:0]    rs1;
    logic [XLEN-1:0]    rs2;
    logic [XLEN-1:0]    imm;
    logic [RFIDX_W-1:0] rdidx;    // Zero when nothing is written
  } alu_req_t;

  typedef struct packed {
    logic [XLEN-1:0]   addr;
    logic [ITAG_W-1:0] itag;
  } lsu_req_t;

  typedef struct packed {
    logic [XLEN-1:0]   rdata;
    logic [ITAG_W-1:0] itag;
  } lsu_rsp_t;

  typedef struct packed {
    logic [RFIDX_W-1:0] rdidx;
    logic [XLEN-1:0]    wdat;
  } wbck_t;

  typedef struct packed {
    logic [RFIDX_W-1:0] rdidx;
    logic               rdwen;
  } oitf_ent_t;

endpackage

`default_nettype wire

// File: hdl/exu_regfile.sv
// Integer register file, 32 entries of XLEN bits.
// Two combinational read ports and one write port fed by the final
// write-back arbiter. x0 has no storage and always reads as zero.

`timescale 1ns/1ps
`default_nettype none

module exu_regfile (
  input  wire                          i_clk,
  input  wire                          i_rst,
  input  wire  [exu_pkg::RFIDX_W-1:0]  i_rs1idx,
  input  wire  [exu_pkg::RFIDX_W-1:0]  i_rs2idx,
  output logic [exu_pkg::XLEN-1:0]     o_rs1,
  output logic [exu_pkg::XLEN-1:0]     o_rs2,
  input  wire                          i_wbck_valid,
  input  wire  exu_pkg::wbck_t         i_wbck
);
  import exu_pkg::*;

  logic [XLEN-1:0] rf_q [1:RF_NUM-1];   // x1 .. x31

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 1; i < RF_NUM; i++) begin
        rf_q[i] <= '0;
      end
    end else if (i_wbck_valid && (i_wbck.rdidx != '0)) begin
      rf_q[i_wbck.rdidx] <= i_wbck.wdat;
    end
  end

  assign o_rs1 = (i_rs1idx == '0) ? '0 : rf_q[i_rs1idx];
  assign o_rs2 = (i_rs2idx == '0) ? '0 : rf_q[i_rs2idx];

  // The arbiter drops x0 writes before they get here
  a_no_x0_write : assert property (
    @(posedge i_clk) disable iff (i_rst)
    i_wbck_valid |-> (i_wbck.rdidx != '0)
  );

endmodule

`default_nettype wire

// File: hdl/exu_disp.sv
// Dispatch stage. Takes one decoded instruction at a time, reads its
// operands and sends it either to the ALU or out to the load unit.
// Loads are recorded in the OITF on the edge the load unit takes them.
// Ready is held low while a hazard, a full OITF or a busy target blocks.

`timescale 1ns/1ps
`default_nettype none

module exu_disp (
  input  wire                          i_clk,
  input  wire                          i_rst,
  input  wire                          i_instr_valid,
  output logic                         o_instr_ready,
  input  wire  exu_pkg::disp_instr_t   i_instr,
  output logic [exu_pkg::RFIDX_W-1:0]  o_rs1idx,
  output logic [exu_pkg::RFIDX_W-1:0]  o_rs2idx,
  input  wire  [exu_pkg::XLEN-1:0]     i_rs1,
  input  wire  [exu_pkg::XLEN-1:0]     i_rs2,
  output logic                         o_alu_valid,
  input  wire                          i_alu_ready,
  output exu_pkg::alu_req_t            o_alu_req,
  output logic                         o_lsu_req_valid,
  input  wire                          i_lsu_req_ready,
  output exu_pkg::lsu_req_t            o_lsu_req,
  output logic                         o_oitf_alloc,
  output exu_pkg::oitf_ent_t           o_oitf_ent,
  input  wire  [exu_pkg::ITAG_W-1:0]   i_oitf_ptr,
  input  wire                          i_oitf_full,
  input  wire                          i_oitf_dep
);
  import exu_pkg::*;

  logic disp_en_q;     // Low through reset and the cycle after
  logic is_load;
  logic hazard_free;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      disp_en_q <= 1'b0;
    end else begin
      disp_en_q <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Operand read and hazard check
  assign o_rs1idx    = i_instr.rs1idx;
  assign o_rs2idx    = i_instr.rs2idx;
  assign is_load     = (i_instr.op == OP_LOAD);
  assign hazard_free = disp_en_q & ~i_oitf_dep;

  ////////////////////////////////////////////////////////////
  // Steering
  assign o_alu_valid     = i_instr_valid & hazard_free & ~is_load;
  assign o_lsu_req_valid = i_instr_valid & hazard_free & is_load & ~i_oitf_full;

  assign o_instr_ready = hazard_free
                       & (is_load ? (~i_oitf_full & i_lsu_req_ready) : i_alu_ready);

  assign o_alu_req.op    = i_instr.op;
  assign o_alu_req.rs1   = i_rs1;
  assign o_alu_req.rs2   = i_rs2;
  assign o_alu_req.imm   = i_instr.imm;
  assign o_alu_req.rdidx = i_instr.rdwen ? i_instr.rdidx : '0;  // No write goes to x0

  // Load address and tag
  assign o_lsu_req.addr = i_rs1 + i_instr.imm;
  assign o_lsu_req.itag = i_oitf_ptr;        // Slot this load will occupy

  assign o_oitf_alloc     = o_lsu_req_valid & i_lsu_req_ready;
  assign o_oitf_ent.rdidx = i_instr.rdidx;
  assign o_oitf_ent.rdwen = i_instr.rdwen;

  a_no_alloc_full : assert property (
    @(posedge i_clk) disable iff (i_rst)
    o_oitf_alloc |-> !i_oitf_full
  );

endmodule

`default_nettype wire

// File: hdl/exu_alu.sv
// Single-cycle ALU for the short integer operations.
// The result lands in an output register on the accept edge and is
// offered to the write-back arbiter until it is taken.

`timescale 1ns/1ps
`default_nettype none

module exu_alu (
  input  wire                      i_clk,
  input  wire                      i_rst,
  input  wire                      i_valid,
  output logic                     o_ready,
  input  wire  exu_pkg::alu_req_t  i_req,
  output logic                     o_wbck_valid,
  input  wire                      i_wbck_ready,
  output exu_pkg::wbck_t           o_wbck
);
  import exu_pkg::*;

  logic            valid_q;
  wbck_t           wbck_q;
  logic [XLEN-1:0] result;

  always_comb begin
    unique case (i_req.op)
      OP_ADD:  result = i_req.rs1 + i_req.rs2;
      OP_SUB:  result = i_req.rs1 - i_req.rs2;
      OP_XOR:  result = i_req.rs1 ^ i_req.rs2;
      OP_OR:   result = i_req.rs1 | i_req.rs2;
      OP_ADDI: result = i_req.rs1 + i_req.imm;
      default: result = '0;   // Loads never reach here
    endcase
  end

  // Empty, or emptying this cycle
  assign o_ready = ~valid_q | i_wbck_ready;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      valid_q <= 1'b0;
    end else if (i_valid && o_ready) begin
      valid_q <= 1'b1;
    end else if (i_wbck_ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid && o_ready) begin
      wbck_q.rdidx <= i_req.rdidx;
      wbck_q.wdat  <= result;
    end
  end

  assign o_wbck_valid = valid_q;
  assign o_wbck       = wbck_q;

  // A result losing arbitration must wait unchanged
  a_hold_stalled : assert property (
    @(posedge i_clk) disable iff (i_rst)
    (o_wbck_valid && !i_wbck_ready) |=> (o_wbck_valid && $stable(o_wbck))
  );

endmodule

`default_nettype wire

// File: hdl/exu_oitf.sv
// Outstanding instruction tracking FIFO for loads in flight.
// Dispatch allocates at the tail when a load leaves, the long-pipe
// write-back retires the head when its response is written.
// Every live entry's rd is compared with the instruction at dispatch.

`timescale 1ns/1ps
`default_nettype none

module exu_oitf (
  input  wire                          i_clk,
  input  wire                          i_rst,
  input  wire                          i_alloc,
  input  wire  exu_pkg::oitf_ent_t     i_ent,
  output logic [exu_pkg::ITAG_W-1:0]   o_alloc_ptr,
  output logic                         o_full,
  output logic                         o_empty,
  input  wire                          i_ret,
  output logic [exu_pkg::ITAG_W-1:0]   o_ret_ptr,
  output exu_pkg::oitf_ent_t           o_ret_ent,
  input  wire  [exu_pkg::RFIDX_W-1:0]  i_rs1idx,
  input  wire  [exu_pkg::RFIDX_W-1:0]  i_rs2idx,
  input  wire  [exu_pkg::RFIDX_W-1:0]  i_rdidx,
  output logic                         o_dep
);
  import exu_pkg::*;

  logic [ITAG_W-1:0]     alloc_ptr_q;
  logic [ITAG_W-1:0]     ret_ptr_q;
  logic                  alloc_wrap_q;
  logic                  ret_wrap_q;
  logic [OITF_DEPTH-1:0] vld_q;
  oitf_ent_t             ent_q [OITF_DEPTH];
  logic [OITF_DEPTH-1:0] dep_hit;

  // Next {wrap, ptr} for a circular pointer
  function automatic logic [ITAG_W:0] ptr_inc(input logic wrap, input logic [ITAG_W-1:0] ptr);
    if (ptr == ITAG_W'(OITF_DEPTH - 1)) begin
      return {~wrap, {ITAG_W{1'b0}}};
    end
    return {wrap, ptr + 1'b1};
  endfunction

  ////////////////////////////////////////////////////////////
  // Pointers and valid bits
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      {alloc_wrap_q, alloc_ptr_q} <= '0;
      {ret_wrap_q, ret_ptr_q}     <= '0;
      vld_q                       <= '0;
    end else begin
      if (i_alloc) {alloc_wrap_q, alloc_ptr_q} <= ptr_inc(alloc_wrap_q, alloc_ptr_q);
      if (i_ret)   {ret_wrap_q, ret_ptr_q}     <= ptr_inc(ret_wrap_q, ret_ptr_q);
      for (int i = 0; i < OITF_DEPTH; i++) begin
        if (i_alloc && (alloc_ptr_q == ITAG_W'(i))) begin
          vld_q[i] <= 1'b1;
        end else if (i_ret && (ret_ptr_q == ITAG_W'(i))) begin
          vld_q[i] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_alloc) ent_q[alloc_ptr_q] <= i_ent;
  end

  // Same slot, wrap flags tell full from empty
  assign o_full      = (alloc_ptr_q == ret_ptr_q) & (alloc_wrap_q != ret_wrap_q);
  assign o_empty     = (alloc_ptr_q == ret_ptr_q) & (alloc_wrap_q == ret_wrap_q);
  assign o_alloc_ptr = alloc_ptr_q;
  assign o_ret_ptr   = ret_ptr_q;
  assign o_ret_ent   = ent_q[ret_ptr_q];

  ////////////////////////////////////////////////////////////
  // Dependency match, x0 never matches
  always_comb begin
    for (int i = 0; i < OITF_DEPTH; i++) begin
      dep_hit[i] = vld_q[i] & ent_q[i].rdwen
                 & (((i_rs1idx != '0) & (i_rs1idx == ent_q[i].rdidx))
                 |  ((i_rs2idx != '0) & (i_rs2idx == ent_q[i].rdidx))
                 |  ((i_rdidx  != '0) & (i_rdidx  == ent_q[i].rdidx)));
    end
  end

  assign o_dep = |dep_hit;

  a_no_ret_empty : assert property (
    @(posedge i_clk) disable iff (i_rst)
    i_ret |-> !o_empty
  );

endmodule

`default_nettype wire

// File: hdl/exu_longpwbck.sv
// Long-pipe write-back for load responses.
// Responses come back in issue order, so each one belongs to the OITF
// head. Its rd comes from that entry and the entry retires on accept.

`timescale 1ns/1ps
`default_nettype none

module exu_longpwbck (
  input  wire                         i_clk,
  input  wire                         i_rst,
  input  wire                         i_rsp_valid,
  output logic                        o_rsp_ready,
  input  wire  exu_pkg::lsu_rsp_t     i_rsp,
  input  wire  [exu_pkg::ITAG_W-1:0]  i_ret_ptr,
  input  wire  exu_pkg::oitf_ent_t    i_ret_ent,
  input  wire                         i_oitf_empty,
  output logic                        o_ret,
  output logic                        o_wbck_valid,
  input  wire                         i_wbck_ready,
  output exu_pkg::wbck_t              o_wbck
);

  assign o_wbck_valid = i_rsp_valid;
  assign o_rsp_ready  = i_wbck_ready;      // Taken when the arbiter takes it

  assign o_wbck.rdidx = i_ret_ent.rdwen ? i_ret_ent.rdidx : '0;
  assign o_wbck.wdat  = i_rsp.rdata;

  // Retire the head on the write-back edge
  assign o_ret = i_rsp_valid & i_wbck_ready & ~i_oitf_empty;

  // In-order return, so the tag must name the head
  a_rsp_matches_head : assert property (
    @(posedge i_clk) disable iff (i_rst)
    i_rsp_valid |-> (!i_oitf_empty && (i_rsp.itag == i_ret_ptr))
  );

endmodule

`default_nettype wire

// File: hdl/exu_wbck.sv
// Final write-back arbiter in front of the register file write port.
// Fixed priority with the long pipe first, since a load response cannot
// be replayed cheaply and the ALU simply holds its result.
// Items for x0 are accepted and then dropped.

`timescale 1ns/1ps
`default_nettype none

module exu_wbck (
  input  wire                     i_alu_valid,
  output logic                    o_alu_ready,
  input  wire  exu_pkg::wbck_t    i_alu,
  input  wire                     i_longp_valid,
  output logic                    o_longp_ready,
  input  wire  exu_pkg::wbck_t    i_longp,
  output logic                    o_rf_valid,
  output exu_pkg::wbck_t          o_rf_wbck
);

  logic longp_grant;
  logic any_valid;

  assign longp_grant   = i_longp_valid;
  assign o_longp_ready = 1'b1;              // Top priority, always granted
  assign o_alu_ready   = ~longp_grant;      // ALU waits behind a load

  assign any_valid = i_longp_valid | i_alu_valid;
  assign o_rf_wbck = longp_grant ? i_longp : i_alu;

  // Suppress the write for x0
  assign o_rf_valid = any_valid & (o_rf_wbck.rdidx != '0);

endmodule

`default_nettype wire

// File: hdl/exu_top.sv
// Execution stage top. Wires dispatch, register file, ALU, OITF,
// long-pipe write-back and the final arbiter together.
// Decoded instructions come in, loads go out to an external load unit
// and every register write is visible on the write-back port.

`timescale 1ns/1ps
`default_nettype none

module exu_top (
  input  wire                          i_clk,
  input  wire                          i_rst,
  input  wire                          i_instr_valid,
  output logic                         o_instr_ready,
  input  wire  exu_pkg::disp_instr_t   i_instr,
  output logic                         o_lsu_req_valid,
  input  wire                          i_lsu_req_ready,
  output exu_pkg::lsu_req_t            o_lsu_req,
  input  wire                          i_lsu_rsp_valid,
  output logic                         o_lsu_rsp_ready,
  input  wire  exu_pkg::lsu_rsp_t      i_lsu_rsp,
  output logic                         o_rf_wbck_valid,
  output exu_pkg::wbck_t               o_rf_wbck,
  output logic                         o_oitf_empty,
  output logic                         o_exu_active
);
  import exu_pkg::*;

  ////////////////////////////////////////////////////////////
  // Internal links
  logic [RFIDX_W-1:0] rs1idx;
  logic [RFIDX_W-1:0] rs2idx;
  logic [XLEN-1:0]    rf_rs1;
  logic [XLEN-1:0]    rf_rs2;

  logic     alu_valid;
  logic     alu_ready;
  alu_req_t alu_req;

  logic              oitf_alloc;
  oitf_ent_t         oitf_ent;
  logic [ITAG_W-1:0] oitf_ptr;
  logic              oitf_full;
  logic              oitf_dep;
  logic              oitf_ret;
  logic [ITAG_W-1:0] oitf_ret_ptr;
  oitf_ent_t         oitf_ret_ent;

  logic  alu_wbck_valid;
  logic  alu_wbck_ready;
  wbck_t alu_wbck;
  logic  longp_wbck_valid;
  logic  longp_wbck_ready;
  wbck_t longp_wbck;

  exu_regfile u_regfile (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_rs1idx     (rs1idx),
    .i_rs2idx     (rs2idx),
    .o_rs1        (rf_rs1),
    .o_rs2        (rf_rs2),
    .i_wbck_valid (o_rf_wbck_valid),
    .i_wbck       (o_rf_wbck)
  );

  exu_disp u_disp (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_instr_valid   (i_instr_valid),
    .o_instr_ready   (o_instr_ready),
    .i_instr         (i_instr),
    .o_rs1idx        (rs1idx),
    .o_rs2idx        (rs2idx),
    .i_rs1           (rf_rs1),
    .i_rs2           (rf_rs2),
    .o_alu_valid     (alu_valid),
    .i_alu_ready     (alu_ready),
    .o_alu_req       (alu_req),
    .o_lsu_req_valid (o_lsu_req_valid),
    .i_lsu_req_ready (i_lsu_req_ready),
    .o_lsu_req       (o_lsu_req),
    .o_oitf_alloc    (oitf_alloc),
    .o_oitf_ent      (oitf_ent),
    .i_oitf_ptr      (oitf_ptr),
    .i_oitf_full     (oitf_full),
    .i_oitf_dep      (oitf_dep)
  );

  exu_alu u_alu (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_valid      (alu_valid),
    .o_ready      (alu_ready),
    .i_req        (alu_req),
    .o_wbck_valid (alu_wbck_valid),
    .i_wbck_ready (alu_wbck_ready),
    .o_wbck       (alu_wbck)
  );

  exu_oitf u_oitf (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_alloc     (oitf_alloc),
    .i_ent       (oitf_ent),
    .o_alloc_ptr (oitf_ptr),
    .o_full      (oitf_full),
    .o_empty     (o_oitf_empty),
    .i_ret       (oitf_ret),
    .o_ret_ptr   (oitf_ret_ptr),
    .o_ret_ent   (oitf_ret_ent),
    .i_rs1idx    (rs1idx),
    .i_rs2idx    (rs2idx),
    .i_rdidx     (oitf_ent.rdidx),   // Dispatch rd for the WAW check
    .o_dep       (oitf_dep)
  );

  exu_longpwbck u_longpwbck (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_rsp_valid  (i_lsu_rsp_valid),
    .o_rsp_ready  (o_lsu_rsp_ready),
    .i_rsp        (i_lsu_rsp),
    .i_ret_ptr    (oitf_ret_ptr),
    .i_ret_ent    (oitf_ret_ent),
    .i_oitf_empty (o_oitf_empty),
    .o_ret        (oitf_ret),
    .o_wbck_valid (longp_wbck_valid),
    .i_wbck_ready (longp_wbck_ready),
    .o_wbck       (longp_wbck)
  );

  exu_wbck u_wbck (
    .i_alu_valid   (alu_wbck_valid),
    .o_alu_ready   (alu_wbck_ready),
    .i_alu         (alu_wbck),
    .i_longp_valid (longp_wbck_valid),
    .o_longp_ready (longp_wbck_ready),
    .i_longp       (longp_wbck),
    .o_rf_valid    (o_rf_wbck_valid),
    .o_rf_wbck     (o_rf_wbck)
  );

  // Work pending anywhere in the stage
  assign o_exu_active = ~o_oitf_empty | alu_wbck_valid | i_instr_valid;

endmodule

`default_nettype wire

// File: tb/tb_exu.sv
// Directed testbench for the execution stage top.
// Models the load unit by hand through tasks, keeps a register model and
// checks every register write against queues of expected write-backs.
// Run through the Makefile in the project root.

`timescale 1ns/1ps
`default_nettype none

module tb_exu;
  import exu_pkg::*;

  localparam int          WAIT_LIMIT = 200;
  localparam logic [31:0] SEED       = 32'h5727_95e8;

  typedef struct packed {
    logic [RFIDX_W-1:0] rd;
    logic [ITAG_W-1:0]  itag;
  } pend_t;

  logic        clk;
  logic        rst;
  logic        instr_valid;
  disp_instr_t instr;
  logic        lsu_req_ready;
  logic        rsp_valid;
  lsu_rsp_t    rsp;
  logic        o_instr_ready;
  logic        o_lsu_req_valid;
  lsu_req_t    o_lsu_req;
  logic        o_lsu_rsp_ready;
  logic        o_rf_wbck_valid;
  wbck_t       o_rf_wbck;
  logic        o_oitf_empty;
  logic        o_exu_active;

  logic [XLEN-1:0]   rf_model [RF_NUM];
  logic [31:0]       lfsr_q;
  logic [ITAG_W-1:0] itag_next;
  pend_t             pending [$];
  wbck_t             alu_exp [$];
  wbck_t             load_exp [$];
  logic              src_log [$];    // 1 for a load write, 0 for ALU
  int                errors;
  int                failed_tests;
  time               accept_time;
  time               rsp_time;

  exu_top i_dut (
    .i_clk           (clk),
    .i_rst           (rst),
    .i_instr_valid   (instr_valid),
    .o_instr_ready   (o_instr_ready),
    .i_instr         (instr),
    .o_lsu_req_valid (o_lsu_req_valid),
    .i_lsu_req_ready (lsu_req_ready),
    .o_lsu_req       (o_lsu_req),
    .i_lsu_rsp_valid (rsp_valid),
    .o_lsu_rsp_ready (o_lsu_rsp_ready),
    .i_lsu_rsp       (rsp),
    .o_rf_wbck_valid (o_rf_wbck_valid),
    .o_rf_wbck       (o_rf_wbck),
    .o_oitf_empty    (o_oitf_empty),
    .o_exu_active    (o_exu_active)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Helpers

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic disp_instr_t make_instr(input alu_op_e op, input int rd, input int rs1,
                                             input int rs2, input logic [31:0] imm);
    disp_instr_t d;
    d.op     = op;
    d.rdidx  = rd[RFIDX_W-1:0];
    d.rs1idx = rs1[RFIDX_W-1:0];
    d.rs2idx = rs2[RFIDX_W-1:0];
    d.rdwen  = 1'b1;
    d.imm    = imm;
    return d;
  endfunction

  // Reference results of the short operations
  function automatic logic [31:0] alu_expect(input alu_op_e op, input logic [31:0] a,
                                             input logic [31:0] b, input logic [31:0] imm);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_XOR:  return a ^ b;
      OP_OR:   return a | b;
      default: return a + imm;
    endcase
  endfunction

  task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  // Called at a falling edge, returns at the next one
  task automatic verify_status(input logic exp_empty, input logic exp_active);
    #1;
    check_hex("o_oitf_empty", 32'(o_oitf_empty), 32'(exp_empty));
    check_hex("o_exu_active", 32'(o_exu_active), 32'(exp_active));
    @(negedge clk);
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      $display("%-28s PASS", name);
    end else begin
      $display("%-28s FAIL (%0d errors)", name, errors - errs_before);
      failed_tests++;
    end
  endtask

  // Called at a falling edge, returns at the falling edge after the transfer
  task automatic issue(input disp_instr_t ins);
    int          waited;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    waited      = 0;
    instr       = ins;
    instr_valid = 1'b1;
    #1;
    while (!o_instr_ready && waited < WAIT_LIMIT) begin
      @(negedge clk);
      #1;
      waited++;
    end
    assert (o_instr_ready) else begin
      $display("Timed out waiting for the DUT to accept an instruction");
      errors++;
    end
    a = rf_model[ins.rs1idx];
    b = rf_model[ins.rs2idx];
    if (ins.op == OP_LOAD) begin
      check_hex("o_lsu_req_valid", 32'(o_lsu_req_valid), 32'd1);
      check_hex("o_lsu_req.addr", o_lsu_req.addr, a + ins.imm);
      check_hex("o_lsu_req.itag", 32'(o_lsu_req.itag), 32'(itag_next));
    end
    @(posedge clk);
    accept_time = $time;
    if (ins.op == OP_LOAD) begin
      pending.push_back('{rd: ins.rdidx, itag: itag_next});
      itag_next = itag_next + 1'b1;
    end else begin
      res = alu_expect(ins.op, a, b, ins.imm);
      if (ins.rdidx != '0) begin
        alu_exp.push_back('{rdidx: ins.rdidx, wdat: res});
        rf_model[ins.rdidx] = res;
      end
    end
    @(negedge clk);
    instr_valid = 1'b0;
  endtask

  // Offers an instruction that must be refused for a number of cycles
  task automatic hold_refused(input disp_instr_t ins, input int cycles);
    instr       = ins;
    instr_valid = 1'b1;
    repeat (cycles) begin
      #1;
      assert (!o_instr_ready) else begin
        $display("Instruction accepted while it should be stalled");
        errors++;
      end
      @(negedge clk);
    end
    instr_valid = 1'b0;
  endtask

  // Load unit answer for the oldest outstanding load
  task automatic respond_one(input int delay);
    int          waited;
    logic [31:0] data;
    pend_t       p;
    waited = 0;
    if (pending.size() == 0) begin
      $display("No outstanding load to answer");
      errors++;
      return;
    end
    p = pending.pop_front();
    repeat (delay) @(negedge clk);
    data      = rand_bits(32);
    rsp.rdata = data;
    rsp.itag  = p.itag;
    rsp_valid = 1'b1;
    if (p.rd != '0) begin
      rf_model[p.rd] = data;
    end
    load_exp.push_back('{rdidx: p.rd, wdat: data});
    #1;
    while (!o_lsu_rsp_ready && waited < WAIT_LIMIT) begin
      @(negedge clk);
      #1;
      waited++;
    end
    assert (o_lsu_rsp_ready) else begin
      $display("Timed out waiting for the DUT to take a load response");
      errors++;
    end
    @(posedge clk);
    rsp_time = $time;
    @(negedge clk);
    rsp_valid = 1'b0;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while ((alu_exp.size() != 0 || load_exp.size() != 0) && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    assert (alu_exp.size() == 0 && load_exp.size() == 0) else begin
      $display("Timed out with expected write-backs never seen");
      errors++;
    end
  endtask

  // Write-back monitor, the source is known from the response handshake
  always @(posedge clk) begin
    if (!rst && rsp_valid && o_lsu_rsp_ready) begin
      src_log.push_back(1'b1);
      if (load_exp.size() == 0) begin
        $display("Load write-back with no expected value");
        errors++;
      end else begin
        check_hex("o_rf_wbck_valid", 32'(o_rf_wbck_valid), 32'd1);
        check_hex("o_rf_wbck.rdidx", 32'(o_rf_wbck.rdidx), 32'(load_exp[0].rdidx));
        check_hex("o_rf_wbck.wdat", o_rf_wbck.wdat, load_exp[0].wdat);
        void'(load_exp.pop_front());
      end
    end else if (!rst && o_rf_wbck_valid) begin
      src_log.push_back(1'b0);
      if (alu_exp.size() == 0) begin
        $display("Unexpected register write to x%0d", o_rf_wbck.rdidx);
        errors++;
      end else begin
        check_hex("o_rf_wbck.rdidx", 32'(o_rf_wbck.rdidx), 32'(alu_exp[0].rdidx));
        check_hex("o_rf_wbck.wdat", o_rf_wbck.wdat, alu_exp[0].wdat);
        void'(alu_exp.pop_front());
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Tests
  task automatic test_reset();
    int e;
    e = errors;
    check_hex("o_lsu_req_valid", 32'(o_lsu_req_valid), 32'd0);
    check_hex("o_rf_wbck_valid", 32'(o_rf_wbck_valid), 32'd0);
    verify_status(1'b1, 1'b0);
    issue(make_instr(OP_ADD, 3, 1, 2, 0));
    verify_status(1'b1, 1'b1);    // ALU result still held
    drain();
    verify_status(1'b1, 1'b0);
    report_test("reset state", e);
  endtask

  task automatic test_alu();
    int e;
    e = errors;
    issue(make_instr(OP_ADDI, 1, 0, 0, 32'h0000_1234));
    issue(make_instr(OP_ADDI, 2, 0, 0, 32'h00ff_0f0f));
    drain();    // No forwarding, a dependent op waits for the write
    issue(make_instr(OP_ADD, 3, 1, 2, 0));
    issue(make_instr(OP_SUB, 4, 1, 2, 0));
    drain();
    issue(make_instr(OP_XOR, 5, 3, 4, 0));
    issue(make_instr(OP_ADD, 0, 1, 2, 0));    // Dropped write
    issue(make_instr(OP_OR, 6, 4, 1, 0));
    drain();
    issue(make_instr(OP_ADDI, 9, 6, 0, 32'hffff_fff0));
    drain();
    report_test("ALU operations", e);
  endtask

  task automatic test_load();
    int e;
    e = errors;
    issue(make_instr(OP_LOAD, 10, 1, 0, 32'h40));
    verify_status(1'b0, 1'b1);    // One load in flight
    respond_one(int'(rand_bits(2)) + 1);
    drain();
    verify_status(1'b1, 1'b0);
    report_test("load path", e);
  endtask

  task automatic test_raw();
    int e;
    e = errors;
    issue(make_instr(OP_LOAD, 5, 2, 0, 32'h8));
    fork
      issue(make_instr(OP_ADD, 11, 5, 1, 0));
      respond_one(int'(rand_bits(2)) + 2);
    join
    assert (accept_time > rsp_time) else begin
      $display("Dependent add dispatched before the load response");
      errors++;
    end
    drain();
    report_test("RAW stall", e);
  endtask

  task automatic test_full();
    int e;
    e = errors;
    issue(make_instr(OP_LOAD, 12, 1, 0, 32'h10));
    issue(make_instr(OP_LOAD, 13, 2, 0, 32'h20));
    hold_refused(make_instr(OP_LOAD, 14, 3, 0, 32'h30), 4);
    respond_one(int'(rand_bits(2)));
    respond_one(int'(rand_bits(2)));
    issue(make_instr(OP_LOAD, 14, 3, 0, 32'h30));
    lsu_req_ready = 1'b0;
    hold_refused(make_instr(OP_LOAD, 15, 4, 0, 32'h44), 3);
    lsu_req_ready = 1'b1;
    issue(make_instr(OP_LOAD, 15, 4, 0, 32'h44));
    respond_one(int'(rand_bits(2)));
    respond_one(int'(rand_bits(2)));
    drain();
    report_test("OITF full and back-pressure", e);
  endtask

  task automatic test_arbitration();
    int e;
    e = errors;
    issue(make_instr(OP_LOAD, 7, 1, 0, 32'h4));
    src_log.delete();
    issue(make_instr(OP_ADD, 8, 1, 2, 0));
    respond_one(0);    // Collides with the ALU result
    drain();
    assert (src_log.size() == 2 && src_log[0] == 1'b1 && src_log[1] == 1'b0) else begin
      $display("Write-backs not seen as load first then ALU");
      errors++;
    end
    report_test("arbitration", e);
  endtask

  initial begin
    lfsr_q        = SEED;
    errors        = 0;
    failed_tests  = 0;
    itag_next     = '0;
    rst           = 1'b1;
    instr_valid   = 1'b0;
    instr         = '0;
    lsu_req_ready = 1'b1;
    rsp_valid     = 1'b0;
    rsp           = '0;
    accept_time   = 0;
    rsp_time      = 0;
    for (int i = 0; i < RF_NUM; i++) begin
      rf_model[i] = '0;
    end
    repeat (4) begin
      @(negedge clk);
      check_hex("o_instr_ready", 32'(o_instr_ready), 32'd0);
    end
    rst = 1'b0;
    @(negedge clk);
    test_reset();
    test_alu();
    test_load();
    test_raw();
    test_full();
    test_arbitration();
    $display("Tests: 6, failed: %0d, errors: %0d", failed_tests, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
hdl/exu_pkg.sv
hdl/exu_regfile.sv
hdl/exu_disp.sv
hdl/exu_alu.sv
hdl/exu_oitf.sv
hdl/exu_longpwbck.sv
hdl/exu_wbck.sv
hdl/exu_top.sv
tb/tb_exu.sv

// File: Makefile
TOP := tb_exu

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Test failures found" sim.log; then exit 1; fi
	@grep -q "All tests passed!" sim.log

obj_dir/V$(TOP): all.f $(wildcard hdl/*.sv tb/*.sv)
	verilator --binary --timing --assert --top-module $(TOP) -f all.f

lint:
	verilator --lint-only -Wall --top-module exu_top \
		hdl/exu_pkg.sv hdl/exu_regfile.sv hdl/exu_disp.sv hdl/exu_alu.sv \
		hdl/exu_oitf.sv hdl/exu_longpwbck.sv hdl/exu_wbck.sv hdl/exu_top.sv

clean:
	rm -rf obj_dir sim.log
